// ==== filelist.f ====
+incdir+.
fpu_pkg.sv
fpu_pipe_delay.sv
fpu_operand_fwd.sv
fpu_op_decode.sv
fpu_simd_exec.sv
fpu_excpt.sv
fpu_unit.sv
fpu_assertions.sv
tb_fpu_unit.sv

// ==== fpu_assertions.sv ====
// latency and reset properties of fpu_unit, attached to every instance through bind
`timescale 1ns/1ps
`default_nettype none

module fpu_assertions (
  input wire                  clk,
  input wire                  rst,
  input fpu_pkg::fpu_issue_t  issue,
  input fpu_pkg::fpu_result_t result
);

  import fpu_pkg::*;

  // issue edge, exec edge, result register edge
  result_latency: assert property (@(posedge clk) disable iff (rst)
    $past(issue.valid, 3) |-> result.valid)
    else $error("result.valid missing three cycles after an issue");

  reset_clears_valid: assert property (@(posedge clk) rst |=> !result.valid)
    else $error("result.valid high while in reset");

  // illegal has priority, so the top code stays unused
  ret_code_range: assert property (@(posedge clk) disable iff (rst)
    result.ret_code != 2'd3)
    else $error("result.ret_code took the unused value 3");

endmodule

bind fpu_unit fpu_assertions u_assertions (
  .clk    (clk),
  .rst    (rst),
  .issue  (issue),
  .result (result)
);

`default_nettype wire

// ==== fpu_defs.svh ====
// widths and opcodes for the two-lane unit; the low two opcode bits are the decoder sub-selector
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// operand holds two single-precision lanes
`define FPU_DATA_W 64
`define FPU_LANE_W 32

// result bypass buses seen by each operand
`define FPU_NUM_BYPASS 4

`define FPU_TAG_W 6
`define FPU_OP_W 8

// logic group 0x1x
`define FPU_OP_AND 8'h10
`define FPU_OP_OR 8'h11
`define FPU_OP_XOR 8'h12
`define FPU_OP_ANDN 8'h13

// lane permute group 0x2x
`define FPU_OP_COPYA 8'h20
`define FPU_OP_SWAPB 8'h21
`define FPU_OP_DUPB 8'h22
`define FPU_OP_MERGE 8'h23

// packed single compare group 0x3x
`define FPU_OP_CMPEQ 8'h30
`define FPU_OP_CMPLT 8'h31

`endif

// ==== fpu_excpt.sv ====
// combinational flag mask and retire code encode; illegal wins over invalid, code 3 is never made
`timescale 1ns/1ps
`default_nettype none

module fpu_excpt (
  input  fpu_pkg::fpu_flags_t flags,
  input  fpu_pkg::fpu_flags_t enable,
  output logic [1:0]          ret_code
);

  import fpu_pkg::*;

  fpu_flags_t raised;

  always_comb begin
    raised.invalid = flags.invalid & enable.invalid;
    raised.illegal = flags.illegal & enable.illegal;
    if (raised.illegal) begin
      ret_code = 2'd2;
    end else if (raised.invalid) begin
      ret_code = 2'd1;
    end else begin
      ret_code = 2'd0;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_op_decode.sv ====
// opcode is captured at the issue edge and decoded after it; unknown codes come out as illegal
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defs.svh"

module fpu_op_decode (
  input  wire                 clk,
  input  wire                 rst,
  input  fpu_pkg::fpu_issue_t issue,
  output fpu_pkg::fpu_ctrl_t  ctrl
);

  import fpu_pkg::*;

  logic                  valid_q;
  logic [`FPU_TAG_W-1:0] tag_q;
  logic [`FPU_OP_W-1:0]  op_q;

  always_ff @(posedge clk) begin
    tag_q <= issue.tag;
    op_q  <= issue.op;
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  always_comb begin
    ctrl.valid = valid_q;
    ctrl.tag   = tag_q;
    // opcodes keep the sub-selector in their two low bits
    ctrl.sub   = op_q[1:0];
    case (op_q)
      `FPU_OP_AND, `FPU_OP_OR, `FPU_OP_XOR, `FPU_OP_ANDN: begin
        ctrl.cls = CLASS_LOGIC;
      end
      `FPU_OP_COPYA, `FPU_OP_SWAPB, `FPU_OP_DUPB, `FPU_OP_MERGE: begin
        ctrl.cls = CLASS_PERM;
      end
      `FPU_OP_CMPEQ, `FPU_OP_CMPLT: begin
        ctrl.cls = CLASS_CMP;
      end
      default: begin
        ctrl.cls = CLASS_NONE;
      end
    endcase
    ctrl.illegal = (ctrl.cls == CLASS_NONE);
  end

endmodule

`default_nettype wire

// ==== fpu_operand_fwd.sv ====
// operand mux with one cycle latency; the select must be one-hot or zero over now and prev
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defs.svh"

module fpu_operand_fwd (
  input  wire                                       clk,
  input  wire                                       rst,
  input  fpu_pkg::fpu_data_t                        value,
  input  fpu_pkg::fpu_fwd_sel_t                     sel,
  input  fpu_pkg::fpu_data_t [`FPU_NUM_BYPASS-1:0] bypass,
  output fpu_pkg::fpu_data_t                        operand
);

  import fpu_pkg::*;

  // bus values seen one clock before the issue edge
  fpu_data_t [`FPU_NUM_BYPASS-1:0] prev_bus;
  fpu_data_t                       fwd_operand;

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_bus <= '0;
    end else begin
      prev_bus <= bypass;
    end
  end

  // now beats prev beats the issue value
  always_comb begin
    fwd_operand = value;
    for (int i = 0; i < `FPU_NUM_BYPASS; i++) begin
      if (sel.prev[i]) begin
        fwd_operand = prev_bus[i];
      end
    end
    for (int i = 0; i < `FPU_NUM_BYPASS; i++) begin
      if (sel.now[i]) begin
        fwd_operand = bypass[i];
      end
    end
  end

  // captured at the issue edge
  always_ff @(posedge clk) begin
    operand <= fwd_operand;
  end

endmodule

`default_nettype wire

// ==== fpu_pipe_delay.sv ====
// fixed delay of depth clocks, depth at least 1; payload_t must have a valid field
`timescale 1ns/1ps
`default_nettype none

module fpu_pipe_delay #(
  parameter type payload_t = fpu_pkg::fpu_result_t,
  parameter int  depth     = 1
) (
  input  wire      clk,
  input  wire      rst,
  input  payload_t d,
  output payload_t q
);

  payload_t stages [depth];

  always_ff @(posedge clk) begin
    stages[0] <= d;
    for (int i = 1; i < depth; i++) begin
      stages[i] <= stages[i-1];
    end
    // only the valid bits are cleared, payload keeps shifting
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        stages[i].valid <= 1'b0;
      end
    end
  end

  assign q = stages[depth-1];

endmodule

`default_nettype wire

// ==== fpu_pkg.sv ====
// shared types of the unit; struct widths follow the macros in fpu_defs.svh
`default_nettype none

`include "fpu_defs.svh"

package fpu_pkg;

  typedef logic [`FPU_DATA_W-1:0] fpu_data_t;

  // one-hot bypass selects, at most one bit set over both fields
  typedef struct packed {
    logic [`FPU_NUM_BYPASS-1:0] now;
    logic [`FPU_NUM_BYPASS-1:0] prev;
  } fpu_fwd_sel_t;

  typedef struct packed {
    logic                 valid;
    logic [`FPU_TAG_W-1:0] tag;
    logic [`FPU_OP_W-1:0]  op;
    fpu_data_t            a;
    fpu_data_t            b;
    fpu_fwd_sel_t         a_sel;
    fpu_fwd_sel_t         b_sel;
  } fpu_issue_t;

  typedef enum logic [1:0] {
    CLASS_LOGIC,
    CLASS_PERM,
    CLASS_CMP,
    CLASS_NONE
  } fpu_class_t;

  typedef struct packed {
    logic                 valid;
    fpu_class_t           cls;
    logic [1:0]           sub;
    logic [`FPU_TAG_W-1:0] tag;
    logic                 illegal;
  } fpu_ctrl_t;

  // raised flags, same layout for the enable mask
  typedef struct packed {
    logic invalid;
    logic illegal;
  } fpu_flags_t;

  typedef struct packed {
    logic                 valid;
    logic [`FPU_TAG_W-1:0] tag;
    fpu_data_t            data;
    logic [1:0]           ret_code;
  } fpu_result_t;

endpackage

`default_nettype wire

// ==== fpu_simd_exec.sv ====
// one-cycle logic, permute and packed single compare stage; flags are zero for idle cycles
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defs.svh"

module fpu_simd_exec (
  input  wire                         clk,
  input  wire                         rst,
  input  fpu_pkg::fpu_ctrl_t          ctrl,
  input  fpu_pkg::fpu_data_t          a,
  input  fpu_pkg::fpu_data_t          b,
  output logic                        valid,
  output logic [`FPU_TAG_W-1:0]       tag,
  output fpu_pkg::fpu_data_t          data,
  output fpu_pkg::fpu_flags_t         flags
);

  import fpu_pkg::*;

  localparam int LW    = `FPU_LANE_W;
  localparam int LANES = `FPU_DATA_W / `FPU_LANE_W;

  fpu_data_t  data_d;
  fpu_flags_t flags_d;

  // exponent all ones with nonzero mantissa
  function automatic logic lane_nan(input logic [LW-1:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  // signaling when the quiet bit is clear
  function automatic logic lane_snan(input logic [LW-1:0] x);
    return lane_nan(x) && !x[22];
  endfunction

  function automatic logic lane_eq(input logic [LW-1:0] x, input logic [LW-1:0] y);
    logic both_zero;
    both_zero = (x[30:0] == '0) && (y[30:0] == '0);
    return !lane_nan(x) && !lane_nan(y) && ((x == y) || both_zero);
  endfunction

  function automatic logic lane_lt(input logic [LW-1:0] x, input logic [LW-1:0] y);
    logic both_zero;
    logic lt;
    both_zero = (x[30:0] == '0) && (y[30:0] == '0);
    if (lane_nan(x) || lane_nan(y) || both_zero) begin
      lt = 1'b0;
    end else if (x[31] != y[31]) begin
      lt = x[31];
    end else if (x[31]) begin
      // both negative, larger magnitude is smaller
      lt = x[30:0] > y[30:0];
    end else begin
      lt = x[30:0] < y[30:0];
    end
    return lt;
  endfunction

  always_comb begin
    data_d  = '0;
    flags_d = '0;
    case (ctrl.cls)
      CLASS_LOGIC: begin
        case (ctrl.sub)
          2'd0:    data_d = a & b;
          2'd1:    data_d = a | b;
          2'd2:    data_d = a ^ b;
          default: data_d = a & ~b;
        endcase
      end
      CLASS_PERM: begin
        case (ctrl.sub)
          2'd0:    data_d = a;
          2'd1:    data_d = {b[LW-1:0], b[2*LW-1:LW]};
          2'd2:    data_d = {b[LW-1:0], b[LW-1:0]};
          default: data_d = {a[2*LW-1:LW], b[LW-1:0]};
        endcase
      end
      CLASS_CMP: begin
        for (int l = 0; l < LANES; l++) begin
          if (ctrl.sub == 2'd1) begin
            data_d[l*LW +: LW] = {LW{lane_lt(a[l*LW +: LW], b[l*LW +: LW])}};
            flags_d.invalid |= lane_nan(a[l*LW +: LW]) | lane_nan(b[l*LW +: LW]);
          end else begin
            data_d[l*LW +: LW] = {LW{lane_eq(a[l*LW +: LW], b[l*LW +: LW])}};
            flags_d.invalid |= lane_snan(a[l*LW +: LW]) | lane_snan(b[l*LW +: LW]);
          end
        end
      end
      default: begin
        flags_d.illegal = ctrl.illegal;
      end
    endcase
    if (!ctrl.valid) begin
      flags_d = '0;
    end
  end

  always_ff @(posedge clk) begin
    tag   <= ctrl.tag;
    data  <= data_d;
    flags <= flags_d;
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= ctrl.valid;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_unit.sv ====
// fixed three-cycle pipeline, no stall or back-pressure; excpt_enable applies in the exec output cycle
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defs.svh"

module fpu_unit (
  input  wire                                       clk,
  input  wire                                       rst,
  input  fpu_pkg::fpu_issue_t                       issue,
  input  fpu_pkg::fpu_data_t [`FPU_NUM_BYPASS-1:0] bypass,
  input  fpu_pkg::fpu_flags_t                       excpt_enable,
  output fpu_pkg::fpu_result_t                      result
);

  import fpu_pkg::*;

  fpu_data_t   opa;
  fpu_data_t   opb;
  fpu_ctrl_t   ctrl;
  fpu_flags_t  exec_flags;
  fpu_result_t exec_res;

  // stage 1, operands and controls
  fpu_operand_fwd u_fwd_a (
    .clk     (clk),
    .rst     (rst),
    .value   (issue.a),
    .sel     (issue.a_sel),
    .bypass  (bypass),
    .operand (opa)
  );

  fpu_operand_fwd u_fwd_b (
    .clk     (clk),
    .rst     (rst),
    .value   (issue.b),
    .sel     (issue.b_sel),
    .bypass  (bypass),
    .operand (opb)
  );

  fpu_op_decode u_decode (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .ctrl  (ctrl)
  );

  // stage 2, execute
  fpu_simd_exec u_exec (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (ctrl),
    .a     (opa),
    .b     (opb),
    .valid (exec_res.valid),
    .tag   (exec_res.tag),
    .data  (exec_res.data),
    .flags (exec_flags)
  );

  fpu_excpt u_excpt (
    .flags    (exec_flags),
    .enable   (excpt_enable),
    .ret_code (exec_res.ret_code)
  );

  // stage 3, result register
  fpu_pipe_delay #(
    .payload_t (fpu_result_t),
    .depth     (1)
  ) u_res_dly (
    .clk (clk),
    .rst (rst),
    .d   (exec_res),
    .q   (result)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the fpu_unit testbench with Verilator 5, result judged from sim.log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f filelist.f --top-module tb_fpu_unit \
    -o tb_fpu_unit; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_fpu_unit > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation ended with an error status"
  exit 1
fi
cat "$LOG"

if grep -qx "TEST RESULT: PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb_fpu_unit.sv ====
// table-driven test of fpu_unit; stops at the first error, each row's excpt_enable is driven two cycles after it issues
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defs.svh"

module tb_fpu_unit;

  import fpu_pkg::*;

  localparam int NUM_ROWS     = 30;
  localparam int RESET_CYCLES = 8;
  localparam int CLK_PERIOD   = 4;
  localparam int WATCHDOG_NS  = (NUM_ROWS + RESET_CYCLES + 20) * CLK_PERIOD;

  // single-precision constants, lanes are {high, low}
  localparam logic [31:0] F_POS_ZERO  = 32'h0000_0000;
  localparam logic [31:0] F_NEG_ZERO  = 32'h8000_0000;
  localparam logic [31:0] F_ONE       = 32'h3f80_0000;
  localparam logic [31:0] F_ONE_HALF  = 32'h3fc0_0000;
  localparam logic [31:0] F_TWO       = 32'h4000_0000;
  localparam logic [31:0] F_NEG_ONE   = 32'hbf80_0000;
  localparam logic [31:0] F_NEG_TWO   = 32'hc000_0000;
  localparam logic [31:0] F_NEG_THREE = 32'hc040_0000;
  localparam logic [31:0] F_QNAN      = 32'h7fc0_0000;
  localparam logic [31:0] F_SNAN      = 32'h7f80_0001;

  localparam fpu_flags_t   EN_ALL     = 2'b11;
  localparam fpu_flags_t   EN_NONE    = 2'b00;
  localparam fpu_flags_t   EN_INVALID = 2'b10;
  localparam fpu_flags_t   EN_ILLEGAL = 2'b01;
  localparam fpu_fwd_sel_t NO_SEL     = '0;
  localparam logic [7:0] BASIC_OPS [8] = '{`FPU_OP_AND, `FPU_OP_OR, `FPU_OP_XOR, `FPU_OP_ANDN,
    `FPU_OP_COPYA, `FPU_OP_SWAPB, `FPU_OP_DUPB, `FPU_OP_MERGE};

  typedef struct packed {
    logic                 valid;
    logic [`FPU_OP_W-1:0] op;
    fpu_fwd_sel_t         a_sel;
    fpu_fwd_sel_t         b_sel;
    fpu_data_t            a;
    fpu_data_t            b;
    fpu_flags_t           en;
    fpu_data_t            exp_data;
    logic [1:0]           exp_code;
  } row_t;

  typedef struct packed {
    logic [`FPU_TAG_W-1:0] tag;
    fpu_data_t             data;
    logic [1:0]            code;
    logic [31:0]           cycle;
  } expect_t;

  logic                            clk = 1'b0;
  logic                            rst;
  fpu_issue_t                      issue;
  fpu_data_t [`FPU_NUM_BYPASS-1:0] bypass;
  fpu_flags_t                      excpt_enable;
  fpu_result_t                     result;

  row_t                            row_tab [NUM_ROWS];
  fpu_data_t [`FPU_NUM_BYPASS-1:0] bus_tab [NUM_ROWS];
  expect_t                         exp_q [$];
  int                              cycle_cnt;

  fpu_unit u_dut (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .bypass       (bypass),
    .excpt_enable (excpt_enable),
    .result       (result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("Mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, want);
    stop_run();
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before all results came back");
  end

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 0);
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // sign-magnitude mapped onto a signed line, both zeros land on 0
  function automatic logic signed [32:0] order_key(input logic [31:0] x);
    logic signed [32:0] mag;
    mag = $signed({2'b00, x[30:0]});
    return x[31] ? -mag : mag;
  endfunction

  function automatic fpu_data_t pick_operand(input fpu_data_t value, input fpu_fwd_sel_t sel,
                                             input int i);
    fpu_data_t opnd;
    opnd = value;
    for (int k = 0; k < `FPU_NUM_BYPASS; k++) begin
      if (sel.now[k]) begin
        opnd = bus_tab[i][k];
      end else if (sel.prev[k] && i > 0) begin
        opnd = bus_tab[i-1][k];
      end
    end
    return opnd;
  endfunction

  // reference behavior of one operation
  task automatic model_op(input logic [7:0] op, input fpu_data_t a, input fpu_data_t b,
                          output fpu_data_t data, output fpu_flags_t flags);
    logic [31:0] x;
    logic [31:0] y;
    logic        ordered;
    logic        hit;
    data  = '0;
    flags = '0;
    case (op)
      `FPU_OP_AND:   data = a & b;
      `FPU_OP_OR:    data = a | b;
      `FPU_OP_XOR:   data = a ^ b;
      `FPU_OP_ANDN:  data = a & ~b;
      `FPU_OP_COPYA: data = a;
      `FPU_OP_SWAPB: data = {b[31:0], b[63:32]};
      `FPU_OP_DUPB:  data = {b[31:0], b[31:0]};
      `FPU_OP_MERGE: data = {a[63:32], b[31:0]};
      `FPU_OP_CMPEQ, `FPU_OP_CMPLT: begin
        for (int l = 0; l < 2; l++) begin
          x = a[32*l +: 32];
          y = b[32*l +: 32];
          ordered = !is_nan(x) && !is_nan(y);
          if (op == `FPU_OP_CMPEQ) begin
            hit = ordered && (order_key(x) == order_key(y));
            flags.invalid = flags.invalid | is_snan(x) | is_snan(y);
          end else begin
            hit = ordered && (order_key(x) < order_key(y));
            flags.invalid = flags.invalid | !ordered;
          end
          data[32*l +: 32] = {32{hit}};
        end
      end
      default: flags.illegal = 1'b1;
    endcase
  endtask

  function automatic logic [1:0] retire_code(input fpu_flags_t flags, input fpu_flags_t en);
    if (flags.illegal && en.illegal) begin
      return 2'd2;
    end
    return (flags.invalid && en.invalid) ? 2'd1 : 2'd0;
  endfunction

  function automatic fpu_fwd_sel_t sel_now(input int k);
    fpu_fwd_sel_t s;
    s = '0;
    s.now[k] = 1'b1;
    return s;
  endfunction

  function automatic fpu_fwd_sel_t sel_prev(input int k);
    fpu_fwd_sel_t s;
    s = '0;
    s.prev[k] = 1'b1;
    return s;
  endfunction

  task automatic set_row(input int i, input logic [7:0] op, input fpu_fwd_sel_t a_sel,
                         input fpu_fwd_sel_t b_sel, input fpu_data_t a, input fpu_data_t b,
                         input fpu_flags_t en);
    row_tab[i].valid = 1'b1;
    row_tab[i].op    = op;
    row_tab[i].a_sel = a_sel;
    row_tab[i].b_sel = b_sel;
    row_tab[i].a     = a;
    row_tab[i].b     = b;
    row_tab[i].en    = en;
  endtask

  task automatic build_table();
    fpu_data_t  a;
    fpu_data_t  b;
    fpu_data_t  d;
    fpu_flags_t flags;
    for (int i = 0; i < NUM_ROWS; i++) begin
      row_tab[i] = '0;
      for (int k = 0; k < `FPU_NUM_BYPASS; k++) begin
        bus_tab[i][k] = {$urandom, $urandom};
      end
    end
    for (int i = 0; i < 8; i++) begin
      set_row(i, BASIC_OPS[i], NO_SEL, NO_SEL, {$urandom, $urandom}, {$urandom, $urandom},
              EN_ALL);
    end
    // every bus through now and prev on both operands
    for (int k = 0; k < `FPU_NUM_BYPASS; k++) begin
      set_row(8 + k, `FPU_OP_XOR, sel_now(k), sel_prev(k), {$urandom, $urandom},
              {$urandom, $urandom}, EN_ALL);
      set_row(12 + k, `FPU_OP_XOR, sel_prev(k), sel_now((k + 1) % 4), {$urandom, $urandom},
              {$urandom, $urandom}, EN_ALL);
    end
    set_row(16, `FPU_OP_CMPEQ, NO_SEL, NO_SEL, {F_POS_ZERO, F_ONE}, {F_NEG_ZERO, F_ONE}, EN_ALL);
    set_row(17, `FPU_OP_CMPLT, NO_SEL, NO_SEL, {F_POS_ZERO, F_ONE}, {F_NEG_ZERO, F_ONE}, EN_ALL);
    set_row(18, `FPU_OP_CMPLT, NO_SEL, NO_SEL, {F_NEG_THREE, F_ONE}, {F_ONE_HALF, F_TWO}, EN_ALL);
    set_row(19, `FPU_OP_CMPLT, NO_SEL, NO_SEL, {F_TWO, F_NEG_ONE}, {F_ONE, F_NEG_TWO}, EN_ALL);
    set_row(20, `FPU_OP_CMPEQ, NO_SEL, NO_SEL, {F_QNAN, F_ONE}, {F_QNAN, F_ONE}, EN_ALL);
    set_row(21, `FPU_OP_CMPLT, NO_SEL, NO_SEL, {F_QNAN, F_ONE}, {F_ONE, F_TWO}, EN_ALL);
    set_row(22, `FPU_OP_CMPLT, NO_SEL, NO_SEL, {F_QNAN, F_ONE}, {F_ONE, F_TWO}, EN_NONE);
    set_row(23, `FPU_OP_CMPEQ, NO_SEL, NO_SEL, {F_SNAN, F_ONE}, {F_ONE, F_ONE}, EN_INVALID);
    set_row(24, `FPU_OP_CMPEQ, NO_SEL, NO_SEL, {F_SNAN, F_ONE}, {F_ONE, F_ONE}, EN_ILLEGAL);
    // rows 25 and 29 stay idle
    set_row(26, 8'h00, NO_SEL, NO_SEL, {$urandom, $urandom}, {$urandom, $urandom}, EN_ALL);
    set_row(27, 8'hff, NO_SEL, NO_SEL, {$urandom, $urandom}, {$urandom, $urandom}, EN_NONE);
    set_row(28, 8'h14, NO_SEL, NO_SEL, {$urandom, $urandom}, {$urandom, $urandom}, EN_ILLEGAL);
    for (int i = 0; i < NUM_ROWS; i++) begin
      a = pick_operand(row_tab[i].a, row_tab[i].a_sel, i);
      b = pick_operand(row_tab[i].b, row_tab[i].b_sel, i);
      model_op(row_tab[i].op, a, b, d, flags);
      row_tab[i].exp_data = d;
      row_tab[i].exp_code = retire_code(flags, row_tab[i].en);
    end
  endtask

  task automatic check_result();
    expect_t e;
    if (result.valid) begin
      assert (exp_q.size() > 0) else report_error("result.valid high with nothing in flight");
      e = exp_q.pop_front();
      assert (cycle_cnt == int'(e.cycle))
        else report_error($sformatf("result for tag %0d came in the wrong cycle", e.tag));
      assert (result.tag == e.tag) else report_mismatch("result.tag", 64'(result.tag), 64'(e.tag));
      assert (result.data == e.data) else report_mismatch("result.data", result.data, e.data);
      assert (result.ret_code == e.code)
        else report_mismatch("result.ret_code", 64'(result.ret_code), 64'(e.code));
    end else begin
      assert (exp_q.size() == 0 || int'(exp_q[0].cycle) != cycle_cnt)
        else report_error("result.valid low when a result was due");
    end
  endtask

  // outputs are checked on the falling edge, before new inputs go out
  task automatic next_cycle();
    @(negedge clk);
    cycle_cnt++;
    check_result();
  endtask

  task automatic drive_row(input int i);
    expect_t e;
    issue.valid = row_tab[i].valid;
    issue.tag   = i[`FPU_TAG_W-1:0];
    issue.op    = row_tab[i].op;
    issue.a     = row_tab[i].a;
    issue.b     = row_tab[i].b;
    issue.a_sel = row_tab[i].a_sel;
    issue.b_sel = row_tab[i].b_sel;
    bypass      = bus_tab[i];
    if (row_tab[i].valid) begin
      e.tag   = i[`FPU_TAG_W-1:0];
      e.data  = row_tab[i].exp_data;
      e.code  = row_tab[i].exp_code;
      e.cycle = cycle_cnt + 3;
      exp_q.push_back(e);
    end
  endtask

  initial begin
    void'($urandom(91984));
    rst          = 1'b1;
    issue        = '0;
    bypass       = '0;
    excpt_enable = EN_ALL;
    cycle_cnt    = 0;
    build_table();
    repeat (RESET_CYCLES) next_cycle();
    rst = 1'b0;
    repeat (2) next_cycle();
    // the enable of a row is used when its exec result retires
    for (int i = 0; i < NUM_ROWS + 2; i++) begin
      next_cycle();
      if (i >= 2) begin
        excpt_enable = row_tab[i-2].en;
      end
      if (i < NUM_ROWS) begin
        drive_row(i);
      end else begin
        issue.valid = 1'b0;
        bypass      = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom,
                       $urandom};
      end
    end
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    repeat (3) next_cycle();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
